// ==== sprite_engine.f ====
sprite_regs_pkg.sv
sprite_video_pkg.sv
axil_sprite_port.sv
sprite_channel.sv
sprite_bank.sv
sprite_priority.sv
sprite_engine.sv
tb_sprite_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sprite engine testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_sprite_engine -f sprite_engine.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
	exit 0
else
	echo "pass line not found in sim.log"
	exit 1
fi

// ==== tb_sprite_engine.sv ====
// sprite engine testbench
`timescale 1ns/10ps

module tb_sprite_engine
	import sprite_regs_pkg::*;
	import sprite_video_pkg::*;
();

localparam int reset_cycles = 10;
localparam int hold_cycles = 4;		// hpos parked at zero before a sweep
localparam int window = 120;		// hpos sweep length
localparam int hs_limit = 20;		// cycles allowed per handshake
localparam int num_rows = 9;
// one extra window for the rearm pass of the disarm row
localparam int watchdog_cycles = reset_cycles + (num_rows + 1) * (window + 40);

typedef enum logic [1:0] {
	kind_pixels,
	kind_read,
	kind_bad_addr,
	kind_backpressure
} kind_e;

typedef struct packed {
	logic used;
	logic [2:0] num;
	logic [8:0] hstart;
	logic attach;			// CTL bit 7
	logic ctl_after;		// CTL rewritten after DATA
} setup_t;

logic clk;
logic reset;
logic [hpos_width-1:0] hpos;
logic sprena;
logic [axil_addr_width-1:0] awaddr;
logic awvalid;
logic awready;
logic [axil_data_width-1:0] wdata;
logic [axil_data_width/8-1:0] wstrb;
logic wvalid;
logic wready;
logic [1:0] bresp;
logic bvalid;
logic bready;
logic [axil_addr_width-1:0] araddr;
logic arvalid;
logic arready;
logic [axil_data_width-1:0] rdata;
logic [1:0] rresp;
logic rvalid;
logic rready;
spr_pixel_t pixel;
logic [11:0] pixel_bits;

// stimulus table
string row_name [num_rows];
setup_t row_a [num_rows];
setup_t row_b [num_rows];
logic row_sprena [num_rows];
kind_e row_kind [num_rows];

// reference model state
logic [15:0] word_a [num_sprites];	// DATA
logic [15:0] word_b [num_sprites];	// DATB
logic [8:0] hs_m [num_sprites];
logic armed_m [num_sprites];
logic att_m [num_sprites];

logic [15:0] lfsr_state = 16'd17;
string cur_name;
int errors;
int failed_tests;

assign pixel_bits = pixel;

sprite_engine UUT
(
	.clk(clk), .reset(reset), .hpos(hpos), .sprena(sprena),
	.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
	.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
	.bresp(bresp), .bvalid(bvalid), .bready(bready),
	.araddr(araddr), .arvalid(arvalid), .arready(arready),
	.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
	.pixel(pixel)
);

initial
begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

// ----------------------------------------------------------
// helpers
// ----------------------------------------------------------

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);	// galois form with taps 16 14 13 11
endfunction

task random_word(output logic [15:0] w);
	w = '0;
	for (int b = 0; b < 16; b++)
	begin
		w = {w[14:0], lfsr_state[0]};		// one step per bit
		lfsr_state = lfsr_next(lfsr_state);
	end
endtask

task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
	if (expected !== actual)
	begin
		$display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
		errors++;
	end
endtask

function automatic setup_t make_setup(input int num, input int hstart, input logic attach,
	input logic ctl_after);
	setup_t s;
	s.used = 1'b1;
	s.num = 3'(num);
	s.hstart = 9'(hstart);
	s.attach = attach;
	s.ctl_after = ctl_after;
	return s;
endfunction

task set_row(input int r, input string name, input setup_t a, input setup_t b,
	input logic en, input kind_e kind);
	row_name[r] = name;
	row_a[r] = a;
	row_b[r] = b;
	row_sprena[r] = en;
	row_kind[r] = kind;
endtask

// expected {nsprite, color} once the beam has passed h
function automatic logic [11:0] expected_pixel(input int h);
	logic [1:0] pix [num_sprites];
	logic [7:0] valid;
	logic [3:0] color;
	logic [15:0] sh_a;
	logic [15:0] sh_b;
	logic found;
	int j;
	valid = '0;
	color = '0;
	found = 1'b0;
	for (int i = 0; i < num_sprites; i++)
	begin
		pix[i] = 2'b00;
		j = h - int'(hs_m[i]) - 3;		// bit 15-j at hstart+3+j
		if (armed_m[i] && j >= 0 && j < 16)
		begin
			sh_a = word_a[i] << j;
			sh_b = word_b[i] << j;
			pix[i] = {sh_b[15], sh_a[15]};
		end
		valid[i] = sprena && pix[i] != 2'b00;
	end
	for (int p = 0; p < num_sprites / 2; p++)	// lowest pair first
		if (!found && (valid[2*p] || valid[2*p+1]))
		begin
			found = 1'b1;
			if (att_m[2*p+1])
				color = {pix[2*p+1], pix[2*p]};
			else if (valid[2*p])
				color = {2'(p), pix[2*p]};
			else
				color = {2'(p), pix[2*p+1]};
		end
	return {valid, color};
endfunction

// ----------------------------------------------------------
// bus tasks entered and left 2 ns after a rising edge
// ----------------------------------------------------------

task send_write(input logic [7:0] addr, input logic [15:0] data);
	int n;
	awaddr = addr;
	wdata = {16'h0000, data};
	awvalid = 1'b1;
	wvalid = 1'b1;
	n = 0;
	#1;
	while (!(awready && wready) && n < hs_limit)
	begin
		@(posedge clk);
		#3;
		n++;
	end
	if (n >= hs_limit)
	begin
		$display("%s: write address and data were never accepted", cur_name);
		errors++;
	end
	@(posedge clk);			// handshake edge
	#2;
	awvalid = 1'b0;
	wvalid = 1'b0;
endtask

task take_bresp(output logic [1:0] resp);
	int n;
	n = 0;
	#1;
	while (!bvalid && n < hs_limit)
	begin
		@(posedge clk);
		#3;
		n++;
	end
	if (n >= hs_limit)
	begin
		$display("%s: write response never arrived", cur_name);
		errors++;
	end
	resp = bresp;
	@(posedge clk);
	#2;
endtask

task axi_read(input logic [7:0] addr, output logic [31:0] data, output logic [1:0] resp);
	int n;
	araddr = addr;
	arvalid = 1'b1;
	n = 0;
	#1;
	while (!arready && n < hs_limit)
	begin
		@(posedge clk);
		#3;
		n++;
	end
	if (n >= hs_limit)
	begin
		$display("%s: read address was never accepted", cur_name);
		errors++;
	end
	@(posedge clk);
	#2;
	arvalid = 1'b0;
	n = 0;
	#1;
	while (!rvalid && n < hs_limit)
	begin
		@(posedge clk);
		#3;
		n++;
	end
	if (n >= hs_limit)
	begin
		$display("%s: read data never arrived", cur_name);
		errors++;
	end
	data = rdata;
	resp = rresp;
	@(posedge clk);
	#2;
endtask

task write_reg(input logic [2:0] num, input spr_reg_e sel, input logic [15:0] data);
	logic [1:0] resp;
	send_write({2'b00, num, sel, 1'b0}, data);
	take_bresp(resp);
	check_value({cur_name, " bresp"}, 32'(resp_okay), 32'(resp));
endtask

// ----------------------------------------------------------
// sprite setup and pixel sweep
// ----------------------------------------------------------

task disarm_all;
	for (int i = 0; i < num_sprites; i++)
	begin
		write_reg(3'(i), reg_ctl, 16'h0000);
		armed_m[i] = 1'b0;
		att_m[i] = 1'b0;
		hs_m[i][0] = 1'b0;		// CTL carries the low hstart bit
	end
endtask

task setup_sprite(input setup_t s);
	logic [15:0] wa;
	logic [15:0] wb;
	logic [15:0] ctl;
	random_word(wb);
	random_word(wa);
	ctl = {8'h00, s.attach, 6'b000000, s.hstart[0]};
	write_reg(s.num, reg_pos, {8'h00, s.hstart[8:1]});
	write_reg(s.num, reg_ctl, ctl);
	write_reg(s.num, reg_datb, wb);
	write_reg(s.num, reg_data, wa);		// arms
	if (s.ctl_after)
		write_reg(s.num, reg_ctl, ctl);	// disarms again
	word_a[s.num] = wa;
	word_b[s.num] = wb;
	hs_m[s.num] = s.hstart;
	att_m[s.num] = s.attach;
	armed_m[s.num] = !s.ctl_after;
endtask

// output checked 1 ns after each edge and hpos moved 1 ns later
task run_window;
	int prev;
	hpos = '0;
	prev = 0;
	repeat (hold_cycles)
	begin
		@(posedge clk);
		#2;
	end
	for (int k = 1; k <= window; k++)
	begin
		@(posedge clk);
		#1;
		check_value($sformatf("%s hpos %0d", cur_name, prev), 32'(expected_pixel(prev)),
			32'(pixel_bits));
		#1;
		hpos = 9'(k);
		prev = k;
	end
	hpos = '0;
endtask

task run_pixel_row(input int r);
	disarm_all();
	sprena = row_sprena[r];
	if (row_a[r].used)
		setup_sprite(row_a[r]);
	if (row_b[r].used)
		setup_sprite(row_b[r]);
	run_window();
	if (row_a[r].ctl_after)		// DATA write rearms and the stream comes back
	begin
		write_reg(row_a[r].num, reg_data, word_a[row_a[r].num]);
		armed_m[row_a[r].num] = 1'b1;
		run_window();
	end
endtask

task run_bad_addr_row;
	logic [15:0] w;
	logic [1:0] resp;
	disarm_all();
	sprena = 1'b1;
	random_word(w);
	send_write(8'h44, w);		// sprite 0 DATA with bit 6 set
	take_bresp(resp);
	check_value({cur_name, " bresp bit 6"}, 32'(resp_slverr), 32'(resp));
	send_write(8'h84, w);		// same with bit 7 set
	take_bresp(resp);
	check_value({cur_name, " bresp bit 7"}, 32'(resp_slverr), 32'(resp));
	run_window();			// nothing armed so nothing shown
endtask

task run_backpressure_row;
	logic [1:0] resp;
	bready = 1'b0;
	send_write(8'h38, 16'h0011);	// sprite 7 POS
	awaddr = 8'h38;			// second write waits behind it
	wdata = 32'h0000_0022;
	awvalid = 1'b1;
	wvalid = 1'b1;
	repeat (6)
	begin
		#1;
		check_value({cur_name, " awready"}, 32'(1'b0), 32'(awready));
		check_value({cur_name, " wready"}, 32'(1'b0), 32'(wready));
		check_value({cur_name, " bvalid"}, 32'(1'b1), 32'(bvalid));
		@(posedge clk);
		#2;
	end
	bready = 1'b1;
	take_bresp(resp);
	check_value({cur_name, " first bresp"}, 32'(resp_okay), 32'(resp));
	send_write(8'h38, 16'h0022);
	take_bresp(resp);
	check_value({cur_name, " second bresp"}, 32'(resp_okay), 32'(resp));
endtask

// ----------------------------------------------------------
// main sequence
// ----------------------------------------------------------

initial
begin
	int start;
	logic [31:0] rd;
	logic [1:0] resp;
	errors = 0;
	failed_tests = 0;
	reset = 1'b1;
	hpos = '0;
	sprena = 1'b0;
	awaddr = '0;
	awvalid = 1'b0;
	wdata = '0;
	wstrb = '1;
	wvalid = 1'b0;
	bready = 1'b1;
	araddr = '0;
	arvalid = 1'b0;
	rready = 1'b1;
	set_row(0, "single_sprite", make_setup(2, 41, 0, 0), '0, 1'b1, kind_pixels);
	set_row(1, "ctl_disarm", make_setup(5, 60, 0, 1), '0, 1'b1, kind_pixels);
	set_row(2, "two_pairs", make_setup(1, 50, 0, 0), make_setup(6, 57, 0, 0), 1'b1,
		kind_pixels);
	set_row(3, "attached_pair", make_setup(2, 70, 0, 0), make_setup(3, 73, 1, 0), 1'b1,
		kind_pixels);
	set_row(4, "unattached_pair", make_setup(4, 60, 0, 0), make_setup(5, 65, 0, 0), 1'b1,
		kind_pixels);
	set_row(5, "sprena_low", make_setup(0, 30, 0, 0), '0, 1'b0, kind_pixels);
	set_row(6, "read_slverr", '0, '0, 1'b0, kind_read);
	set_row(7, "bad_address", '0, '0, 1'b1, kind_bad_addr);
	set_row(8, "bready_stall", '0, '0, 1'b0, kind_backpressure);
	repeat (reset_cycles) @(posedge clk);
	#2;
	reset = 1'b0;
	for (int r = 0; r < num_rows; r++)
	begin
		cur_name = row_name[r];
		start = errors;
		case (row_kind[r])
			kind_pixels:
				run_pixel_row(r);
			kind_read:
			begin
				axi_read(8'h10, rd, resp);
				check_value({cur_name, " rdata"}, 32'h0, rd);
				check_value({cur_name, " rresp"}, 32'(resp_slverr), 32'(resp));
			end
			kind_bad_addr:
				run_bad_addr_row();
			default:
				run_backpressure_row();
		endcase
		if (errors != start)
			failed_tests++;
		$display("%-16s %s, %0d errors", cur_name, (errors == start) ? "ok" : "failed",
			errors - start);
	end
	$display("tests %0d, failed %0d, errors %0d", num_rows, failed_tests, errors);
	if (errors == 0)
		$display("PASS: all tests");
	else
		$display("FAIL: see errors above");
	$finish;
end

// hang guard
initial
begin
	repeat (watchdog_cycles) @(posedge clk);
	$display("watchdog: run did not finish within %0d clock cycles", watchdog_cycles);
	$display("FAIL: see errors above");
	$finish;
end

endmodule

// ==== sprite_engine.sv ====
// sprite engine top
`timescale 1ns/10ps

module sprite_engine
	import sprite_regs_pkg::*;
	import sprite_video_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [hpos_width-1:0] hpos,		// beam counter from outside
	input logic sprena,
	// axi4-lite slave
	input logic [axil_addr_width-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [axil_data_width-1:0] wdata,
	input logic [axil_data_width/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [axil_addr_width-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [axil_data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	// video out
	output spr_pixel_t pixel
);

spr_reg_wr_t reg_wr;		// port to bank
spr_bits_arr_t spr_bits;	// bank to priority

// ----------------------------------------------------------
// host side
// ----------------------------------------------------------

axil_sprite_port u_port
(
	.clk(clk),
	.reset(reset),
	.awaddr(awaddr),
	.awvalid(awvalid),
	.awready(awready),
	.wdata(wdata),
	.wstrb(wstrb),
	.wvalid(wvalid),
	.wready(wready),
	.bresp(bresp),
	.bvalid(bvalid),
	.bready(bready),
	.araddr(araddr),
	.arvalid(arvalid),
	.arready(arready),
	.rdata(rdata),
	.rresp(rresp),
	.rvalid(rvalid),
	.rready(rready),
	.reg_wr(reg_wr)
);

// ----------------------------------------------------------
// sprites and output
// ----------------------------------------------------------

sprite_bank u_bank
(
	.clk(clk),
	.reset(reset),
	.reg_wr(reg_wr),
	.hpos(hpos),
	.spr_bits(spr_bits)
);

sprite_priority u_prio
(
	.clk(clk),
	.reset(reset),
	.sprena(sprena),
	.spr_bits(spr_bits),
	.pixel(pixel)		// registered
);

endmodule

// ==== sprite_priority.sv ====
// sprite priority and color decode
`timescale 1ns/10ps

module sprite_priority
	import sprite_video_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic sprena,				// sprite dma enable
	input spr_bits_arr_t spr_bits,
	output spr_pixel_t pixel
);

logic [num_sprites-1:0] nsprite;	// nonzero pixel per sprite
logic [color_width-1:0] color;

// ----------------------------------------------------------
// valid flags
// ----------------------------------------------------------

always_comb
begin
	for (int i = 0; i < num_sprites; i++)
		nsprite[i] = sprena && spr_bits[i].pix != '0;	// 00 is transparent
end

// ----------------------------------------------------------
// pair priority and color
// ----------------------------------------------------------

// highest pair first so that the lowest pair overwrites
always_comb
begin
	spr_bits_t even_spr;
	spr_bits_t odd_spr;

	color = '0;		// nothing visible
	even_spr = '0;
	odd_spr = '0;
	for (int p = num_pairs - 1; p >= 0; p--)
	begin
		if (nsprite[2*p +: 2] != 2'b00)
		begin
			even_spr = spr_bits[2*p];
			odd_spr = spr_bits[2*p+1];
			if (odd_spr.attach)		// attached pair, 15 colors
				color = {odd_spr.pix, even_spr.pix};
			else if (nsprite[2*p])		// even sprite in front
				color = {pix_width'(p), even_spr.pix};
			else
				color = {pix_width'(p), odd_spr.pix};
		end
	end
end

// ----------------------------------------------------------
// output register
// ----------------------------------------------------------

always_ff @(posedge clk)
	if (reset)
		pixel <= '0;
	else
	begin
		pixel.nsprite <= nsprite;
		pixel.color <= color;
	end

endmodule

// ==== sprite_bank.sv ====
// bank of eight sprite channels
`timescale 1ns/10ps

module sprite_bank
	import sprite_regs_pkg::*;
	import sprite_video_pkg::*;
(
	input logic clk,
	input logic reset,
	input spr_reg_wr_t reg_wr,			// one write per strobe
	input logic [hpos_width-1:0] hpos,
	output spr_bits_arr_t spr_bits
);

logic [num_sprites-1:0] wr_en;		// per-channel write enable

// ----------------------------------------------------------
// sprite number decode and channels
// ----------------------------------------------------------

genvar i;
generate
	for (i = 0; i < num_sprites; i++)
	begin : g_chan
		// only the addressed sprite sees the write
		assign wr_en[i] = reg_wr.valid &&
			reg_wr.sprite == ($bits(reg_wr.sprite))'(i);

		sprite_channel u_chan
		(
			.clk(clk),
			.reset(reset),
			.wr_en(wr_en[i]),
			.sel(reg_wr.sel),		// shared select
			.data(reg_wr.data),		// shared data word
			.hpos(hpos),
			.bits(spr_bits[i])
		);
	end
endgenerate

endmodule

// ==== sprite_channel.sv ====
// single sprite serializer
`timescale 1ns/10ps

module sprite_channel
	import sprite_regs_pkg::*;
	import sprite_video_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic wr_en,				// register write for this sprite
	input spr_reg_e sel,
	input logic [spr_data_width-1:0] data,
	input logic [hpos_width-1:0] hpos,		// beam position
	output spr_bits_t bits
);

logic [hpos_width-1:0] hstart;		// horizontal start
logic [spr_data_width-1:0] datla;	// DATA word
logic [spr_data_width-1:0] datlb;	// DATB word
logic [spr_data_width-1:0] shifta;
logic [spr_data_width-1:0] shiftb;
logic armed;
logic attach;
logic load;				// start match seen
logic load_del;				// one cycle later, loads the shifters

// ----------------------------------------------------------
// registers
// ----------------------------------------------------------

always_ff @(posedge clk)
	if (wr_en && sel == reg_pos)
		hstart[hpos_width-1:1] <= data[hpos_width-2:0];	// POS bits 7:0
	else if (wr_en && sel == reg_ctl)
		hstart[0] <= data[0];				// low bit lives in CTL

always_ff @(posedge clk)
	if (reset)
		attach <= 1'b0;
	else if (wr_en && sel == reg_ctl)
		attach <= data[7];

always_ff @(posedge clk)
	if (wr_en && sel == reg_data)
		datla <= data;

always_ff @(posedge clk)
	if (wr_en && sel == reg_datb)
		datlb <= data;

// CTL write disarms, DATA write arms
always_ff @(posedge clk)
	if (reset)
		armed <= 1'b0;
	else if (wr_en && sel == reg_ctl)
		armed <= 1'b0;
	else if (wr_en && sel == reg_data)
		armed <= 1'b1;

// ----------------------------------------------------------
// start and shift
// ----------------------------------------------------------

// stays armed, fires again on every match
always_ff @(posedge clk)
	if (reset)
	begin
		load <= 1'b0;
		load_del <= 1'b0;
	end
	else
	begin
		load <= armed && hpos == hstart;
		load_del <= load;
	end

always_ff @(posedge clk)
	if (reset)
	begin
		shifta <= '0;
		shiftb <= '0;
	end
	else if (load_del)	// take the latched words
	begin
		shifta <= datla;
		shiftb <= datlb;
	end
	else			// msb first, zeros behind
	begin
		shifta <= {shifta[spr_data_width-2:0], 1'b0};
		shiftb <= {shiftb[spr_data_width-2:0], 1'b0};
	end

always_comb
begin
	bits.attach = attach;
	bits.pix = {shiftb[spr_data_width-1], shifta[spr_data_width-1]};
end

endmodule

// ==== axil_sprite_port.sv ====
// axi4-lite sprite register port
`timescale 1ns/10ps

module axil_sprite_port
	import sprite_regs_pkg::*;
(
	input logic clk,
	input logic reset,
	// write address and data
	input logic [axil_addr_width-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [axil_data_width-1:0] wdata,
	input logic [axil_data_width/8-1:0] wstrb,	// whole words only, not looked at
	input logic wvalid,
	output logic wready,
	// write response
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	// read channel, registers are write-only
	input logic [axil_addr_width-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [axil_data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	// register write strobe to the bank
	output spr_reg_wr_t reg_wr
);

typedef enum logic {
	wr_idle,
	wr_resp
} wr_state_e;

typedef enum logic {
	rd_idle,
	rd_resp
} rd_state_e;

wr_state_e wr_state;
rd_state_e rd_state;

logic wr_accept;		// address and data taken this cycle
logic wr_in_range;		// address hits a sprite register
logic wr_valid;			// registered strobe
logic [addr_spr_msb-addr_spr_lsb:0] wr_sprite;
spr_reg_e wr_sel;
logic [spr_data_width-1:0] wr_data;

// ----------------------------------------------------------
// write channel
// ----------------------------------------------------------

// both channels together, never while a response waits
assign wr_accept = wr_state == wr_idle && awvalid && wvalid;
assign wr_in_range = awaddr[addr_range_msb:addr_range_lsb] == '0;

assign awready = wr_accept;
assign wready = wr_accept;
assign bvalid = wr_state == wr_resp;

always_ff @(posedge clk)
	if (reset)
		wr_state <= wr_idle;
	else
	begin
		case (wr_state)
			wr_idle:
				if (wr_accept)
					wr_state <= wr_resp;
			wr_resp:
				if (bready)		// response taken
					wr_state <= wr_idle;
			default:
				wr_state <= wr_idle;
		endcase
	end

// strobe lasts one cycle, only for in-range writes
always_ff @(posedge clk)
	if (reset)
		wr_valid <= 1'b0;
	else
		wr_valid <= wr_accept && wr_in_range;

// split the address, keep the low half of wdata
always_ff @(posedge clk)
	if (wr_accept)
	begin
		wr_sprite <= awaddr[addr_spr_msb:addr_spr_lsb];
		wr_sel <= spr_reg_e'(awaddr[addr_sel_msb:addr_sel_lsb]);
		wr_data <= wdata[spr_data_width-1:0];
		bresp <= wr_in_range ? resp_okay : resp_slverr;	// held with bvalid
	end

always_comb
begin
	reg_wr.valid = wr_valid;
	reg_wr.sprite = wr_sprite;
	reg_wr.sel = wr_sel;
	reg_wr.data = wr_data;
end

// ----------------------------------------------------------
// read channel
// ----------------------------------------------------------

// every read is refused, araddr does not matter
assign arready = rd_state == rd_idle && arvalid;
assign rvalid = rd_state == rd_resp;
assign rdata = '0;
assign rresp = resp_slverr;

always_ff @(posedge clk)
	if (reset)
		rd_state <= rd_idle;
	else
	begin
		case (rd_state)
			rd_idle:
				if (arvalid)
					rd_state <= rd_resp;
			rd_resp:
				if (rready)
					rd_state <= rd_idle;
			default:
				rd_state <= rd_idle;
		endcase
	end

endmodule

// ==== sprite_video_pkg.sv ====
// sprite video types
package sprite_video_pkg;

	// ----------------------------------------------------------
	// sizes
	// ----------------------------------------------------------
	localparam int num_sprites = 8;
	localparam int num_pairs = num_sprites / 2;	// sprites share colors in pairs
	localparam int pix_width = 2;			// bits per sprite pixel
	localparam int color_width = 2 * pix_width;	// pair number over pixel, or attached
	localparam int hpos_width = 9;			// horizontal beam counter

	// per-channel serial output
	typedef struct packed {
		logic attach;				// CTL bit 7
		logic [pix_width-1:0] pix;		// B bit high, A bit low
	} spr_bits_t;

	typedef spr_bits_t [num_sprites-1:0] spr_bits_arr_t;

	// registered engine output
	typedef struct packed {
		logic [num_sprites-1:0] nsprite;	// one valid flag per sprite
		logic [color_width-1:0] color;
	} spr_pixel_t;

endpackage

// ==== sprite_regs_pkg.sv ====
// sprite register map
package sprite_regs_pkg;

	// ----------------------------------------------------------
	// bus widths
	// ----------------------------------------------------------
	localparam int axil_addr_width = 8;		// byte address
	localparam int axil_data_width = 32;
	localparam int spr_data_width = 16;		// sprite registers are 16-bit words

	// address fields, bit 0 is the byte within a word
	localparam int addr_range_msb = 7;		// must be zero for a sprite register
	localparam int addr_range_lsb = 6;
	localparam int addr_spr_msb = 5;		// sprite number
	localparam int addr_spr_lsb = 3;
	localparam int addr_sel_msb = 2;		// register within the sprite
	localparam int addr_sel_lsb = 1;

	// axi response codes
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// register select, same order as the chip's POS/CTL/DATA/DATB
	typedef enum logic [1:0] {
		reg_pos = 2'b00,
		reg_ctl = 2'b01,
		reg_data = 2'b10,
		reg_datb = 2'b11
	} spr_reg_e;

	// one register write, as handed to the sprite bank
	typedef struct packed {
		logic valid;
		logic [addr_spr_msb-addr_spr_lsb:0] sprite;
		spr_reg_e sel;
		logic [spr_data_width-1:0] data;
	} spr_reg_wr_t;

endpackage
